/* Bender.yml */
package:
  name: udp_reassembly

sources:
  - udp_reassembly_pkg.sv
  - sync_fifo.sv
  - fragment_slot.sv
  - fragment_dispatcher.sv
  - drain_arbiter.sv
  - udp_reassembly_top.sv
  - target: simulation
    files:
      - tb_udp_reassembly_assert.sv
      - tb_udp_reassembly.sv

/* drain_arbiter.sv */
module drain_arbiter import udp_reassembly_pkg::*; #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic [NUM_SLOTS-1:0] drain_request,
    input  slot_entry_t          drain_beat [NUM_SLOTS],
    input  packet_id_t           slot_packet_id [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] drain_pop,
    output out_beat_t            out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    logic [NUM_SLOTS-1:0] grant;
    logic [NUM_SLOTS-1:0] first_request;
    logic [NUM_SLOTS-1:0] active;
    logic                 out_transfer;

    // Lowest requesting slot
    assign first_request = drain_request & (~drain_request + 1'b1);

    assign active       = grant & drain_request;
    assign out_valid    = |active;
    assign out_transfer = out_valid && out_ready;
    assign drain_pop    = active & {NUM_SLOTS{out_ready}};

    ////////////////////////////////////////////////////////////////////
    // Output multiplexer
    ////////////////////////////////////////////////////////////////////

    // Grant is one-hot, at most one slot drives the beat
    always_comb begin
        out_beat = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (grant[i]) begin
                out_beat.data      = drain_beat[i].data;
                out_beat.packet_id = slot_packet_id[i];
                out_beat.last      = drain_beat[i].end_of_packet;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Locked grant
    ////////////////////////////////////////////////////////////////////

    // Held until the last byte of the datagram leaves
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            grant <= '0;
        end else if (grant == '0) begin
            grant <= first_request;
        end else if (out_transfer && out_beat.last) begin
            grant <= '0;
        end
    end

endmodule

/* fragment_dispatcher.sv */
module fragment_dispatcher import udp_reassembly_pkg::*; #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                 in_valid,
    output logic                 in_ready,
    input  in_beat_t             in_beat,
    input  logic [NUM_SLOTS-1:0] slot_free,
    input  logic [NUM_SLOTS-1:0] slot_capturing,
    input  packet_id_t           slot_packet_id [NUM_SLOTS],
    output logic [NUM_SLOTS-1:0] slot_write
);

    logic [NUM_SLOTS-1:0] id_match;
    logic [NUM_SLOTS-1:0] match_one_hot;
    logic [NUM_SLOTS-1:0] free_one_hot;
    logic [NUM_SLOTS-1:0] target;
    logic                 any_match;
    logic                 transfer;

    ////////////////////////////////////////////////////////////////////
    // Identifier match against open slots
    ////////////////////////////////////////////////////////////////////

    // Only capturing slots can take more bytes of their datagram
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            id_match[i] = slot_capturing[i] &&
                          (slot_packet_id[i] == in_beat.packet_id);
        end
    end

    // Lowest set bit keeps the write one-hot
    assign match_one_hot = id_match & (~id_match + 1'b1);
    assign any_match     = |id_match;

    ////////////////////////////////////////////////////////////////////
    // Free slot search
    ////////////////////////////////////////////////////////////////////

    // Priority encoder, lowest index wins
    assign free_one_hot = slot_free & (~slot_free + 1'b1);

    // An existing datagram beats a new claim
    assign target = any_match ? match_one_hot : free_one_hot;

    ////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////

    // Stall when nothing matches and every slot is busy
    assign in_ready = |target;
    assign transfer = in_valid && in_ready;

    assign slot_write = transfer ? target : '0;

endmodule

/* fragment_slot.sv */
module fragment_slot import udp_reassembly_pkg::*; #(
    parameter int SLOT_DEPTH = 512
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        write,
    input  in_beat_t    beat,
    output logic        free,
    output logic        capturing,
    output packet_id_t  packet_id,
    output logic        drain_request,
    output slot_entry_t drain_beat,
    input  logic        drain_pop
);

    slot_state_t state;
    slot_state_t next_state;
    slot_entry_t buffer_entry;
    logic        buffer_valid;
    logic        accept;
    logic        end_of_packet;
    logic        fifo_empty;

    ////////////////////////////////////////////////////////////////////
    // Datagram storage
    ////////////////////////////////////////////////////////////////////

    // Full flag left open, datagrams stay below the depth
    sync_fifo #(
        .DATA_WIDTH (SLOT_ENTRY_WIDTH),
        .DATA_DEPTH (SLOT_DEPTH)
    ) slot_fifo (
        .clock        (clock),
        .reset_n      (reset_n),
        .write_enable (buffer_valid),
        .write_data   (buffer_entry),
        .read_enable  (drain_pop),
        .read_data    (drain_beat),
        .empty        (fifo_empty),
        .full         ()
    );

    // Final byte of the final fragment closes the datagram
    assign end_of_packet = beat.fragment_end && beat.final_fragment;

    ////////////////////////////////////////////////////////////////////
    // Slot FSM
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        accept     = 1'b0;
        case (state)
            SLOT_IDLE: begin
                if (write) begin
                    accept     = 1'b1;
                    next_state = end_of_packet ? SLOT_DRAIN : SLOT_CAPTURE;
                end
            end
            SLOT_CAPTURE: begin
                if (write) begin
                    accept = 1'b1;
                    if (end_of_packet) begin
                        next_state = SLOT_DRAIN;
                    end
                end
            end
            SLOT_DRAIN: begin
                // Wait for the buffered last byte to land before testing empty
                if (fifo_empty && !buffer_valid) begin
                    next_state = SLOT_IDLE;
                end
            end
            default: begin
                next_state = SLOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= SLOT_IDLE;
            free         <= 1'b0;
            capturing    <= 1'b0;
            buffer_valid <= 1'b0;
        end else begin
            state        <= next_state;
            free         <= (next_state == SLOT_IDLE);
            capturing    <= (next_state == SLOT_CAPTURE);
            buffer_valid <= accept;
        end
    end

    // One-byte staging register ahead of the FIFO
    always_ff @(posedge clock) begin
        if (accept) begin
            buffer_entry.data          <= beat.data;
            buffer_entry.end_of_packet <= end_of_packet;
        end
    end

    // Identifier taken from the first byte only
    always_ff @(posedge clock) begin
        if (state == SLOT_IDLE && write) begin
            packet_id <= beat.packet_id;
        end
    end

    assign drain_request = (state == SLOT_DRAIN) && !fifo_empty;

endmodule

/* sync_fifo.sv */
module sync_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DATA_DEPTH = 512
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  write_enable,
    input  logic [DATA_WIDTH-1:0] write_data,
    input  logic                  read_enable,
    output logic [DATA_WIDTH-1:0] read_data,
    output logic                  empty,
    output logic                  full
);

    localparam int ADDRESS_WIDTH = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
    localparam int COUNT_WIDTH   = $clog2(DATA_DEPTH + 1);

    logic [DATA_WIDTH-1:0]    memory [DATA_DEPTH];
    logic [ADDRESS_WIDTH-1:0] write_pointer;
    logic [ADDRESS_WIDTH-1:0] read_pointer;
    logic [COUNT_WIDTH-1:0]   count;
    logic                     do_write;
    logic                     do_read;

    // Wrap at the configured depth, not only at a power of two
    function automatic logic [ADDRESS_WIDTH-1:0] advance(input logic [ADDRESS_WIDTH-1:0] pointer);
        if (pointer == ADDRESS_WIDTH'(DATA_DEPTH - 1)) begin
            return '0;
        end
        return pointer + 1'b1;
    endfunction

    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    assign empty = (count == '0);
    assign full  = (count == COUNT_WIDTH'(DATA_DEPTH));

    // Show-ahead read port, head entry always visible
    assign read_data = memory[read_pointer];

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (do_write) begin
                write_pointer <= advance(write_pointer);
            end
            if (do_read) begin
                read_pointer <= advance(read_pointer);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* tb_udp_reassembly.sv */
module tb_udp_reassembly import udp_reassembly_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_SLOTS       = 4;
    localparam int          SLOT_DEPTH      = 512;
    localparam int          CLOCK_PERIOD    = 100;
    localparam int          RESET_CYCLES    = 5;
    localparam logic [15:0] LFSR_SEED       = 16'd23;
    localparam int          MAX_DATAGRAMS   = 5;
    localparam int          MAX_FRAGMENTS   = 3;
    localparam int          CYCLES_PER_BYTE = 20;
    localparam int          SLACK_CYCLES    = 200;
    localparam int          NUM_TESTS       = 6;

    typedef struct {
        string name;
        int    datagram_count;
        bit    round_robin;
        bit    throttle;
        bit    expect_stall;
        int    id_base;
        int    fragment_length [MAX_DATAGRAMS][MAX_FRAGMENTS];
    } test_row_t;

    // Fragment lengths per datagram, a zero ends its fragment list
    test_row_t test_table [NUM_TESTS] = '{
        '{"single_fragment", 1, 0, 0, 0, 'h0100,
          '{'{12, 0, 0}, '{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}}},
        '{"three_fragments", 1, 0, 0, 0, 'h0200,
          '{'{5, 7, 4}, '{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}, '{0, 0, 0}}},
        '{"four_interleaved", 4, 1, 0, 0, 'h0300,
          '{'{3, 4, 2}, '{6, 0, 0}, '{2, 5, 0}, '{1, 1, 1}, '{0, 0, 0}}},
        '{"five_with_stall", 5, 1, 0, 1, 'h0400,
          '{'{12, 0, 0}, '{2, 4, 0}, '{1, 2, 2}, '{2, 1, 0}, '{4, 3, 0}}},
        '{"throttled_interleaved", 3, 1, 1, 0, 'h0500,
          '{'{9, 5, 0}, '{7, 0, 0}, '{4, 4, 4}, '{0, 0, 0}, '{0, 0, 0}}},
        '{"throttled_sequential", 5, 0, 1, 0, 'h0600,
          '{'{16, 0, 0}, '{1, 0, 0}, '{8, 8, 0}, '{3, 3, 3}, '{20, 0, 0}}}
    };

    logic       clock;
    logic       reset_n;
    in_beat_t   in_beat;
    logic       in_valid;
    logic       in_ready;
    out_beat_t  out_beat;
    logic       out_valid;
    logic       out_ready;

    logic [15:0] data_lfsr;
    logic [15:0] ready_lfsr;
    bit          throttle_enable;
    string       current_test;
    int          scoreboard_index [packet_id_t];
    logic [7:0]  expected_data [MAX_DATAGRAMS][$];
    int          expected_pos [MAX_DATAGRAMS];
    bit          drained [MAX_DATAGRAMS];
    int          active_index;
    int          received_count;
    int          drained_count;
    int          stall_cycles;
    int          value_errors;
    int          protocol_errors;

    udp_reassembly_top #(
        .NUM_SLOTS  (NUM_SLOTS),
        .SLOT_DEPTH (SLOT_DEPTH)
    ) UUT (
        .clock     (clock),
        .reset_n   (reset_n),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic next_payload_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            value[i]  = data_lfsr[0];
        end
    endtask

    function automatic int test_byte_count(input int t);
        int total;
        total = 0;
        for (int d = 0; d < MAX_DATAGRAMS; d++) begin
            for (int f = 0; f < MAX_FRAGMENTS; f++) begin
                total += test_table[t].fragment_length[d][f];
            end
        end
        return total;
    endfunction

    function automatic int total_byte_count();
        int total;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += test_byte_count(t);
        end
        return total;
    endfunction

    task automatic send_byte(input in_beat_t beat);
        @(negedge clock);
        in_beat  = beat;
        in_valid = 1'b1;
        @(posedge clock);
        while (!in_ready) begin
            stall_cycles++;
            @(posedge clock);
        end
    endtask

    task automatic send_fragment(input int t, input int d, input int f);
        in_beat_t beat;
        int       offset;
        int       length;
        bit       final_one;
        offset = 0;
        for (int i = 0; i < f; i++) begin
            offset += test_table[t].fragment_length[d][i];
        end
        length    = test_table[t].fragment_length[d][f];
        final_one = (f == MAX_FRAGMENTS - 1) ||
                    (test_table[t].fragment_length[d][f + 1] == 0);
        for (int b = 0; b < length; b++) begin
            beat.data           = expected_data[d][offset + b];
            beat.packet_id      = packet_id_t'(test_table[t].id_base + d);
            beat.fragment_end   = (b == length - 1);
            beat.final_fragment = final_one;
            send_byte(beat);
        end
    endtask

    // Output back-pressure, full rate unless the row throttles it
    always @(negedge clock) begin
        if (!throttle_enable) begin
            out_ready = 1'b1;
        end else begin
            ready_lfsr = lfsr_step(ready_lfsr);
            out_ready  = ready_lfsr[0];
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Scoreboard
    ////////////////////////////////////////////////////////////////////

    task automatic check_output_beat();
        int index;
        int pos;
        bit known;
        bit expected_last;
        known = scoreboard_index.exists(out_beat.packet_id);
        assert (known) else begin
            protocol_errors++;
            $display("Test %s: unexpected identifier %h on the output",
                     current_test, out_beat.packet_id);
        end
        if (!known) begin
            return;
        end
        index = scoreboard_index[out_beat.packet_id];
        pos   = expected_pos[index];
        assert (active_index < 0 || active_index == index) else begin
            protocol_errors++;
            $display("Test %s: datagram %h started inside another datagram",
                     current_test, out_beat.packet_id);
        end
        assert (pos < expected_data[index].size()) else begin
            protocol_errors++;
            $display("Test %s: datagram %h has more bytes than were sent",
                     current_test, out_beat.packet_id);
        end
        if (pos >= expected_data[index].size()) begin
            return;
        end
        expected_last = (pos == expected_data[index].size() - 1);
        assert (out_beat.data == expected_data[index][pos]) else begin
            value_errors++;
            $display("[FAIL] %s data of %h byte %0d: expected %h, actual %h", current_test,
                     out_beat.packet_id, pos, expected_data[index][pos], out_beat.data);
        end
        assert (out_beat.last == expected_last) else begin
            value_errors++;
            $display("[FAIL] %s last of %h byte %0d: expected %b, actual %b", current_test,
                     out_beat.packet_id, pos, expected_last, out_beat.last);
        end
        expected_pos[index] = pos + 1;
        active_index        = out_beat.last ? -1 : index;
        if (out_beat.last) begin
            drained_count++;
            drained[index] = 1'b1;
        end
    endtask

    always @(posedge clock) begin
        if (reset_n) begin
            // Nothing may drain before a whole datagram has arrived
            assert (!out_valid || received_count > drained_count) else begin
                protocol_errors++;
                $display("Test %s: out_valid high with no complete datagram stored",
                         current_test);
            end
            if (in_valid && in_ready && in_beat.fragment_end && in_beat.final_fragment) begin
                received_count++;
            end
            if (out_valid && out_ready) begin
                check_output_beat();
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    task automatic run_test(input int t);
        int         count;
        int         drained_target;
        int         wait_cycles;
        int         limit;
        int         length;
        logic [7:0] value;
        count           = test_table[t].datagram_count;
        current_test    = test_table[t].name;
        throttle_enable = test_table[t].throttle;
        stall_cycles    = 0;
        drained_target  = drained_count + count;
        scoreboard_index.delete();
        for (int d = 0; d < MAX_DATAGRAMS; d++) begin
            expected_data[d].delete();
            expected_pos[d] = 0;
            drained[d]      = 1'b0;
        end
        // Expected datagram is its fragments back to back
        for (int d = 0; d < count; d++) begin
            scoreboard_index[packet_id_t'(test_table[t].id_base + d)] = d;
            length = test_table[t].fragment_length[d][0] +
                     test_table[t].fragment_length[d][1] +
                     test_table[t].fragment_length[d][2];
            for (int b = 0; b < length; b++) begin
                next_payload_byte(value);
                expected_data[d].push_back(value);
            end
        end
        for (int outer = 0; outer < MAX_DATAGRAMS; outer++) begin
            for (int inner = 0; inner < MAX_DATAGRAMS; inner++) begin
                if (test_table[t].round_robin) begin
                    if (outer < MAX_FRAGMENTS && inner < count &&
                            test_table[t].fragment_length[inner][outer] > 0) begin
                        send_fragment(t, inner, outer);
                    end
                end else if (outer < count && inner < MAX_FRAGMENTS &&
                        test_table[t].fragment_length[outer][inner] > 0) begin
                    send_fragment(t, outer, inner);
                end
            end
        end
        @(negedge clock);
        in_valid = 1'b0;
        limit       = test_byte_count(t) * CYCLES_PER_BYTE + SLACK_CYCLES;
        wait_cycles = 0;
        while (drained_count < drained_target && wait_cycles < limit) begin
            @(negedge clock);
            wait_cycles++;
        end
        for (int d = 0; d < count; d++) begin
            assert (drained[d]) else begin
                protocol_errors++;
                $display("Test %s: datagram %h never drained", current_test,
                         packet_id_t'(test_table[t].id_base + d));
            end
        end
        if (test_table[t].expect_stall) begin
            assert (stall_cycles > 0) else begin
                protocol_errors++;
                $display("Test %s: in_ready never dropped while all slots were busy",
                         current_test);
            end
        end
        // Drained slots go back to idle
        repeat (4) @(negedge clock);
    endtask

    initial begin
        clock           = 1'b0;
        reset_n         = 1'b0;
        in_valid        = 1'b0;
        in_beat         = '0;
        out_ready       = 1'b0;
        throttle_enable = 1'b0;
        data_lfsr       = LFSR_SEED;
        ready_lfsr      = LFSR_SEED;
        current_test    = "reset";
        active_index    = -1;
        received_count  = 0;
        drained_count   = 0;
        value_errors    = 0;
        protocol_errors = 0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset_n = 1'b1;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Error count: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the total byte count of the table
    initial begin
        #((total_byte_count() * CYCLES_PER_BYTE + SLACK_CYCLES + RESET_CYCLES) * CLOCK_PERIOD);
        $display("Watchdog expired in test %s, the run did not finish", current_test);
        $display("Errors found");
        $finish;
    end

endmodule

/* tb_udp_reassembly_assert.sv */
module tb_udp_reassembly_assert import udp_reassembly_pkg::*; (
    input logic      clock,
    input logic      reset_n,
    input logic      in_ready,
    input out_beat_t out_beat,
    input logic      out_valid,
    input logic      out_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // Output beat holds while the consumer stalls
    property output_held;
        @(posedge clock) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat);
    endproperty

    // Both handshakes stay quiet in reset
    property quiet_in_reset;
        @(posedge clock) !reset_n |-> !out_valid && !in_ready;
    endproperty

    // A datagram keeps the output until its last byte
    property datagram_contiguous;
        @(posedge clock) disable iff (!reset_n)
        out_valid && out_ready && !out_beat.last |=>
            out_valid && out_beat.packet_id == $past(out_beat.packet_id);
    endproperty

    assert property (output_held)
        else $error("out_beat changed while out_valid waited for out_ready");
    assert property (quiet_in_reset)
        else $error("out_valid or in_ready high during reset");
    assert property (datagram_contiguous)
        else $error("second packet_id on the output before last");

endmodule

bind udp_reassembly_top tb_udp_reassembly_assert protocol_checks (
    .clock     (clock),
    .reset_n   (reset_n),
    .in_ready  (in_ready),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

/* udp_reassembly_pkg.sv */
package udp_reassembly_pkg;

    ////////////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH      = 8;
    localparam int PACKET_ID_WIDTH = 16;

    typedef logic [PACKET_ID_WIDTH-1:0] packet_id_t;

    ////////////////////////////////////////////////////////////////////
    // Stream beats
    ////////////////////////////////////////////////////////////////////

    // Input byte with its datagram tag and fragment markers
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        packet_id_t            packet_id;
        logic                  fragment_end;
        logic                  final_fragment;
    } in_beat_t;

    // Reassembled output byte
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        packet_id_t            packet_id;
        logic                  last;
    } out_beat_t;

    // One word of a slot FIFO
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  end_of_packet;
    } slot_entry_t;

    localparam int SLOT_ENTRY_WIDTH = $bits(slot_entry_t);

    // Slot life cycle
    typedef enum logic [1:0] {
        SLOT_IDLE,
        SLOT_CAPTURE,
        SLOT_DRAIN
    } slot_state_t;

endpackage

/* udp_reassembly_top.sv */
module udp_reassembly_top import udp_reassembly_pkg::*; #(
    parameter int NUM_SLOTS  = 4,
    parameter int SLOT_DEPTH = 512
) (
    input  logic      clock,
    input  logic      reset_n,
    input  in_beat_t  in_beat,
    input  logic      in_valid,
    output logic      in_ready,
    output out_beat_t out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    logic [NUM_SLOTS-1:0] slot_write;
    logic [NUM_SLOTS-1:0] slot_free;
    logic [NUM_SLOTS-1:0] slot_capturing;
    packet_id_t           slot_packet_id [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] drain_request;
    slot_entry_t          drain_beat [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] drain_pop;

    fragment_dispatcher #(
        .NUM_SLOTS (NUM_SLOTS)
    ) dispatcher (
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_beat        (in_beat),
        .slot_free      (slot_free),
        .slot_capturing (slot_capturing),
        .slot_packet_id (slot_packet_id),
        .slot_write     (slot_write)
    );

    // One reassembly slot per concurrent datagram
    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        fragment_slot #(
            .SLOT_DEPTH (SLOT_DEPTH)
        ) slot (
            .clock         (clock),
            .reset_n       (reset_n),
            .write         (slot_write[i]),
            .beat          (in_beat),
            .free          (slot_free[i]),
            .capturing     (slot_capturing[i]),
            .packet_id     (slot_packet_id[i]),
            .drain_request (drain_request[i]),
            .drain_beat    (drain_beat[i]),
            .drain_pop     (drain_pop[i])
        );
    end

    drain_arbiter #(
        .NUM_SLOTS (NUM_SLOTS)
    ) arbiter (
        .clock          (clock),
        .reset_n        (reset_n),
        .drain_request  (drain_request),
        .drain_beat     (drain_beat),
        .slot_packet_id (slot_packet_id),
        .drain_pop      (drain_pop),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

endmodule

/* verilog.f */
udp_reassembly_pkg.sv
sync_fifo.sv
fragment_slot.sv
fragment_dispatcher.sv
drain_arbiter.sv
udp_reassembly_top.sv
tb_udp_reassembly_assert.sv
tb_udp_reassembly.sv
